// File: host_link.f
source/host_link_pkg.sv
source/msg_fifo.sv
source/coeff_reducer.sv
source/host_rd_port.sv
source/host_link_top.sv
sim/tb_clk_gen.sv
sim/host_link_chk.sv
sim/host_link_tb.sv

// File: Bender.yml
package:
  name: host_link

sources:
  - source/host_link_pkg.sv
  - source/msg_fifo.sv
  - source/coeff_reducer.sv
  - source/host_rd_port.sv
  - source/host_link_top.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/host_link_chk.sv
      - sim/host_link_tb.sv

// File: sim/host_link_tb.sv
`timescale 1ns/100ps
`default_nettype none

module host_link_tb;

  import host_link_pkg::*;

  logic         bus_clk;
  logic         rst;
  host_wr_req_t wr;
  logic         wr_open;
  logic         wr_full;
  host_rd_req_t rd_req;
  host_rd_rsp_t rd_rsp;
  host_rd_rsp_t loop_rsp;

  // Stream as written, and what each channel should return
  msg_t words[$];
  msg_t rd_q[$];
  msg_t loop_q[$];
  int   err_count = 0;

  tb_clk_gen clk_gen (.bus_clk(bus_clk), .rst(rst));

  host_link_top dut0 (
    .bus_clk  (bus_clk),
    .rst      (rst),
    .wr       (wr),
    .wr_open  (wr_open),
    .wr_full  (wr_full),
    .rd_req   (rd_req),
    .rd_rsp   (rd_rsp),
    .loop_rsp (loop_rsp)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        err_count++;
      end
  endtask

  task automatic report(input string what);
    $display("Check failed: %s", what);
    err_count++;
  endtask

  initial begin
    int          i;
    int          n_data;
    int          limit;
    int          cycles;
    int          wr_idx;
    int          rd_count;
    int          loop_count;
    int          chk_fails;
    bit          paused;
    bit          seen_full;
    bit          drained;
    msg_t        coeff;
    msg_t        d;
    logic [63:0] prod;

    wr      = '0;
    wr_open = 1'b1;
    rd_req  = '0;
    void'($urandom(32'hfc46791a));

    // ********************
    // Build the stream
    // ********************
    coeff  = $urandom();
    n_data = $urandom_range(79, 40);
    words.push_back(coeff);
    for (i = 0; i < n_data; i++) begin
      d = $urandom();
      if (d == MSG_EOF) d[0] = 1'b0;
      words.push_back(d);
      // Full product, reduced modulo 2^32
      prod = 64'(d) * 64'(coeff);
      rd_q.push_back(prod[31:0]);
    end
    words.push_back(MSG_EOF);
    loop_q = words;
    limit  = 40 * words.size() + 200;

    cycles     = 0;
    wr_idx     = 0;
    rd_count   = 0;
    loop_count = 0;
    paused     = 1'b1;
    seen_full  = 1'b0;
    drained    = 1'b0;
    @(negedge bus_clk);
    while (rst) @(negedge bus_clk);

    // ********************
    // Main loop
    // ********************
    while (!drained && cycles < limit) begin
      assert (!(rd_rsp.eof && rd_q.size() != 0))
        else report("read eof high while results are still pending");
      assert (!(loop_rsp.eof && wr_open))
        else report("loopback eof high while the write side is open");
      seen_full |= wr_full;
      drained = (wr_idx == words.size()) && (rd_q.size() == 0) && (loop_q.size() == 0)
                && rd_rsp.eof && loop_rsp.eof;

      wr.wren = 1'b0;
      if (wr_idx < words.size() && !wr_full && $urandom_range(3) != 0) begin
        wr.wren = 1'b1;
        wr.data = words[wr_idx];
        wr_idx++;
      end else if (wr_idx == words.size()) begin
        wr_open = 1'b0;
      end

      // Reads held off at first, then paused in long random stretches
      if (cycles >= 80 && $urandom_range(31) == 0) paused = !paused;
      rd_req = '0;
      if (!paused && !rd_rsp.empty && $urandom_range(1) == 1) begin
        rd_req.rd_rden = 1'b1;
        rd_count++;
        assert (rd_q.size() > 0) else report("read channel returned an extra word");
        if (rd_q.size() > 0) check_value("read data", rd_q.pop_front(), rd_rsp.data);
      end
      if (!paused && !loop_rsp.empty && $urandom_range(1) == 1) begin
        rd_req.loop_rden = 1'b1;
        loop_count++;
        assert (loop_q.size() > 0) else report("loopback channel returned an extra word");
        if (loop_q.size() > 0) check_value("loopback data", loop_q.pop_front(), loop_rsp.data);
      end
      cycles++;
      @(negedge bus_clk);
    end

    rd_req  = '0;
    wr.wren = 1'b0;
    if (!drained) begin
      $display("Timeout: channels not drained within %0d cycles", limit);
      err_count++;
    end else begin
      check_value("read count", n_data, rd_count);
      check_value("loopback count", words.size(), loop_count);
      assert (seen_full) else report("write FIFO never filled under back-pressure");
      repeat (5) @(negedge bus_clk);
      assert (rd_rsp.eof && loop_rsp.eof) else report("eof flags dropped after the drain");
    end

    chk_fails = dut0.chk0.fail_count;
    $display("Errors: %0d testbench checks, %0d assertion checks", err_count, chk_fails);
    if (err_count == 0 && chk_fails == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/host_link_chk.sv
`timescale 1ns/100ps
`default_nettype none

module host_link_chk (
  input wire                         bus_clk,
  input wire                         rst,
  input wire                         wr_full,
  input wire                         fpga_msg_valid,
  input wire                         loop_msg_valid,
  input wire                         msg_ready,
  input wire                         loop_ready,
  input host_link_pkg::host_rd_rsp_t rd_rsp,
  input host_link_pkg::host_rd_rsp_t loop_rsp
);

  int fail_count = 0;

  // First cycle out of reset
  reset_flags: assert property (@(posedge bus_clk) $fell(rst) |->
      rd_rsp.empty && loop_rsp.empty && !wr_full && !rd_rsp.eof && !loop_rsp.eof)
    else begin
      $error("channel flags not in their reset state after reset");
      fail_count++;
    end

  // Reducer never pushes into a full FIFO
  no_push_when_full: assert property (@(posedge bus_clk) disable iff (rst)
      (!fpga_msg_valid || msg_ready) && (!loop_msg_valid || loop_ready))
    else begin
      $error("reducer pushed into a full read or loopback FIFO");
      fail_count++;
    end

  // Read eof is sticky until reset
  rd_eof_stays: assert property (@(posedge bus_clk) disable iff (rst)
      rd_rsp.eof |=> rd_rsp.eof)
    else begin
      $error("read eof dropped after it rose");
      fail_count++;
    end

endmodule

bind host_link_top host_link_chk chk0 (.*);

`default_nettype wire

// File: sim/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int RESET_CYCLES = 10
) (
  output logic bus_clk,
  output logic rst
);

  // 4 ns period
  initial begin
    bus_clk = 1'b0;
    forever #2 bus_clk = ~bus_clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// File: source/host_link_top.sv
`timescale 1ns/100ps
`default_nettype none

module host_link_top #(
  parameter int WR_DEPTH   = host_link_pkg::DEFAULT_DEPTH,
  parameter int RD_DEPTH   = host_link_pkg::DEFAULT_DEPTH,
  parameter int LOOP_DEPTH = host_link_pkg::DEFAULT_DEPTH
) (
  input  wire                         bus_clk,
  input  wire                         rst,
  // Host write channel
  input  host_link_pkg::host_wr_req_t wr,
  input  wire                         wr_open,
  output logic                        wr_full,
  // Host read and loopback channels
  input  host_link_pkg::host_rd_req_t rd_req,
  output host_link_pkg::host_rd_rsp_t rd_rsp,
  output host_link_pkg::host_rd_rsp_t loop_rsp
);

  import host_link_pkg::*;

  // Write FIFO to reducer
  msg_t pc_msg;
  logic pc_msg_empty;
  logic pc_msg_ack;

  // Reducer to read port
  msg_t fpga_msg;
  logic fpga_msg_valid;
  logic loop_msg_valid;
  logic app_done;
  logic msg_ready;
  logic loop_ready;

  // ********************
  // Input side
  // ********************

  msg_fifo #(
    .DEPTH (WR_DEPTH)
  ) wr_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (wr.wren),
    .din     (wr.data),
    .rd_en   (pc_msg_ack),
    .dout    (pc_msg),
    .full    (wr_full),
    .empty   (pc_msg_empty)
  );

  // ********************
  // Processing
  // ********************

  coeff_reducer reducer (
    .bus_clk        (bus_clk),
    .rst            (rst),
    .pc_msg         (pc_msg),
    .pc_msg_empty   (pc_msg_empty),
    .pc_msg_ack     (pc_msg_ack),
    .msg_ready      (msg_ready),
    .loop_ready     (loop_ready),
    .fpga_msg       (fpga_msg),
    .fpga_msg_valid (fpga_msg_valid),
    .loop_msg_valid (loop_msg_valid),
    .app_done       (app_done)
  );

  // ********************
  // Output side
  // ********************

  // Loopback takes the write FIFO head directly
  host_rd_port #(
    .RD_DEPTH   (RD_DEPTH),
    .LOOP_DEPTH (LOOP_DEPTH)
  ) rd_port (
    .bus_clk        (bus_clk),
    .rst            (rst),
    .fpga_msg       (fpga_msg),
    .fpga_msg_valid (fpga_msg_valid),
    .loop_msg       (pc_msg),
    .loop_msg_valid (loop_msg_valid),
    .app_done       (app_done),
    .wr_open        (wr_open),
    .rd_req         (rd_req),
    .msg_ready      (msg_ready),
    .loop_ready     (loop_ready),
    .rd_rsp         (rd_rsp),
    .loop_rsp       (loop_rsp)
  );

endmodule

`default_nettype wire

// File: source/host_rd_port.sv
`timescale 1ns/100ps
`default_nettype none

module host_rd_port #(
  parameter int RD_DEPTH   = host_link_pkg::DEFAULT_DEPTH,
  parameter int LOOP_DEPTH = host_link_pkg::DEFAULT_DEPTH
) (
  input  wire                         bus_clk,
  input  wire                         rst,
  // Results from the reducer
  input  host_link_pkg::msg_t         fpga_msg,
  input  wire                         fpga_msg_valid,
  // Loopback copy of every consumed word
  input  host_link_pkg::msg_t         loop_msg,
  input  wire                         loop_msg_valid,
  input  wire                         app_done,
  input  wire                         wr_open,
  input  host_link_pkg::host_rd_req_t rd_req,
  output logic                        msg_ready,
  output logic                        loop_ready,
  output host_link_pkg::host_rd_rsp_t rd_rsp,
  output host_link_pkg::host_rd_rsp_t loop_rsp
);

  import host_link_pkg::*;

  msg_t rd_dout;
  logic rd_full;
  logic rd_empty;
  msg_t loop_dout;
  logic loop_full;
  logic loop_empty;

  // ********************
  // Read channel
  // ********************

  msg_fifo #(
    .DEPTH (RD_DEPTH)
  ) rd_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (fpga_msg_valid),
    .din     (fpga_msg),
    .rd_en   (rd_req.rd_rden),
    .dout    (rd_dout),
    .full    (rd_full),
    .empty   (rd_empty)
  );

  assign msg_ready = !rd_full;

  // Stream ends once the terminator is consumed and results are drained
  assign rd_rsp = '{
    data:  rd_dout,
    empty: rd_empty,
    eof:   app_done && rd_empty
  };

  // ********************
  // Loopback channel
  // ********************

  msg_fifo #(
    .DEPTH (LOOP_DEPTH)
  ) loop_fifo (
    .bus_clk (bus_clk),
    .rst     (rst),
    .wr_en   (loop_msg_valid),
    .din     (loop_msg),
    .rd_en   (rd_req.loop_rden),
    .dout    (loop_dout),
    .full    (loop_full),
    .empty   (loop_empty)
  );

  assign loop_ready = !loop_full;

  // Host closed its write side and every copy has been read back
  assign loop_rsp = '{
    data:  loop_dout,
    empty: loop_empty,
    eof:   !wr_open && loop_empty
  };

endmodule

`default_nettype wire

// File: source/coeff_reducer.sv
`timescale 1ns/100ps
`default_nettype none

module coeff_reducer (
  input  wire                 bus_clk,
  input  wire                 rst,
  // Head of the write FIFO
  input  host_link_pkg::msg_t pc_msg,
  input  wire                 pc_msg_empty,
  output logic                pc_msg_ack,
  // Room in the read and loopback FIFOs
  input  wire                 msg_ready,
  input  wire                 loop_ready,
  // Pushes toward the read port
  output host_link_pkg::msg_t fpga_msg,
  output logic                fpga_msg_valid,
  output logic                loop_msg_valid,
  output logic                app_done
);

  import host_link_pkg::*;

  reducer_state_e state;
  reducer_state_e state_next;
  msg_t           coeff;
  logic           is_eof;
  logic           msg_present;

  assign msg_present = !pc_msg_empty;
  assign is_eof      = (pc_msg == MSG_EOF);

  // Product keeps only the low 32 bits
  assign fpga_msg = pc_msg * coeff;

  assign app_done = (state == RED_DONE);

  // ********************
  // Consume decision
  // ********************

  always_comb begin
    pc_msg_ack     = 1'b0;
    fpga_msg_valid = 1'b0;
    loop_msg_valid = 1'b0;
    state_next     = state;
    case (state)
      RED_LOAD: begin
        // First word is the coefficient, echoed to loopback only
        if (msg_present && loop_ready) begin
          pc_msg_ack     = 1'b1;
          loop_msg_valid = 1'b1;
          state_next     = RED_STREAM;
        end
      end
      RED_STREAM: begin
        if (msg_present) begin
          if (is_eof) begin
            // Terminator goes to loopback, never to the read channel
            if (loop_ready) begin
              pc_msg_ack     = 1'b1;
              loop_msg_valid = 1'b1;
              state_next     = RED_DONE;
            end
          end else if (msg_ready && loop_ready) begin
            // Data word needs room on both sides
            pc_msg_ack     = 1'b1;
            fpga_msg_valid = 1'b1;
            loop_msg_valid = 1'b1;
          end
        end
      end
      RED_DONE: begin
        // Nothing consumed until reset
        state_next = RED_DONE;
      end
      default: begin
        state_next = RED_LOAD;
      end
    endcase
  end

  // ********************
  // State and coefficient
  // ********************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      state <= RED_LOAD;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge bus_clk) begin
    if ((state == RED_LOAD) && pc_msg_ack) begin
      coeff <= pc_msg;
    end
  end

endmodule

`default_nettype wire

// File: source/msg_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module msg_fifo #(
  parameter int DEPTH = host_link_pkg::DEFAULT_DEPTH
) (
  input  wire                 bus_clk,
  input  wire                 rst,
  input  wire                 wr_en,
  input  host_link_pkg::msg_t din,
  input  wire                 rd_en,
  output host_link_pkg::msg_t dout,
  output logic                full,
  output logic                empty
);

  import host_link_pkg::*;

  // Pointer and occupancy widths
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  msg_t          mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_wr;
  logic          do_rd;

  // Requests against a full or empty buffer are dropped here
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);

  // Show-ahead head word
  assign dout = mem[rd_ptr];

  // ********************
  // Storage
  // ********************

  always_ff @(posedge bus_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // ********************
  // Pointers and count
  // ********************

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        if (wr_ptr == AW'(DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (do_rd) begin
        if (rd_ptr == AW'(DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // Simultaneous push and pop leaves the count alone
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/host_link_pkg.sv
`default_nettype none

package host_link_pkg;

  // ********************
  // Message word
  // ********************

  // One host message, 32 bits wide
  typedef logic [31:0] msg_t;

  // All-ones word closes the stream
  localparam msg_t MSG_EOF = '1;

  // Default FIFO depth for all three channels
  localparam int DEFAULT_DEPTH = 16;

  // ********************
  // Reducer states
  // ********************

  typedef enum logic [1:0] {
    RED_LOAD,
    RED_STREAM,
    RED_DONE
  } reducer_state_e;

  // ********************
  // Host channels
  // ********************

  // Write channel from the host
  typedef struct packed {
    logic wren;
    msg_t data;
  } host_wr_req_t;

  // Read strobes for the read and loopback channels
  typedef struct packed {
    logic rd_rden;
    logic loop_rden;
  } host_rd_req_t;

  // One read-type channel back to the host
  typedef struct packed {
    msg_t data;
    logic empty;
    logic eof;
  } host_rd_rsp_t;

endpackage

`default_nettype wire
